// File: include/dram_defines.svh
`ifndef DRAM_DEFINES_SVH
`define DRAM_DEFINES_SVH

// address geometry
`define DRAM_BG_BITS 2
`define DRAM_BANK_BITS 1
`define DRAM_ROW_BITS 8
`define DRAM_COL_BITS 4
`define DRAM_DATA_BITS 32

// bank group and bank together form the flat bank number
`define DRAM_NUM_BANKS (1 << (`DRAM_BG_BITS + `DRAM_BANK_BITS))

`define DRAM_QUEUE_DEPTH 8

// wait cycles after an accepted command
`define DRAM_PRE_LATENCY 5
`define DRAM_ACT_LATENCY 8
`define DRAM_READ_GAP 4    // between two reads

`endif

// File: sources.f
+incdir+include
verilog/dram_geom_pkg.sv
verilog/dram_cmd_pkg.sv
verilog/request_queue.sv
verilog/bank_state_table.sv
verilog/timing_counter.sv
verilog/cmd_sequencer.sv
verilog/dram_scheduler_top.sv
testbench/scheduler_sva.sv
testbench/scheduler_checker.sv
testbench/tb_dram_scheduler.sv

// File: testbench/scheduler_checker.sv
`timescale 1ns/1ns
`include "dram_defines.svh"

module scheduler_checker import dram_geom_pkg::*, dram_cmd_pkg::*; (
    input  logic clk_in,
    input  logic rst_in,
    input  logic req_valid,
    input  dram_addr_t req_addr,
    input  logic req_write,
    input  logic [`DRAM_DATA_BITS-1:0] req_data,
    input  logic req_ready,
    input  logic cmd_ready,
    input  logic cmd_valid,
    input  dram_cmd_t cmd_code,
    input  bank_idx_t cmd_bank,
    input  row_t cmd_row,
    input  col_t cmd_col,
    input  logic [`DRAM_DATA_BITS-1:0] cmd_data,
    output int done_count,    // requests whose read or write went out
    output int err_count
);
    sched_req_t pending [$];
    logic model_open [`DRAM_NUM_BANKS];
    row_t model_row [`DRAM_NUM_BANKS];
    longint cycle;
    longint last_cycle;
    longint last_read;
    dram_cmd_t last_code;

    // next command the head request needs from the state of its bank
    function automatic dram_cmd_t expected_cmd(logic is_open, row_t cur_row, sched_req_t req);
        if (!is_open) begin
            return CMD_ACTIVATE;
        end
        if (cur_row != req.addr.f.row) begin
            return CMD_PRECHARGE;
        end
        return req.write ? CMD_WRITE : CMD_READ;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_command();
        sched_req_t head;
        bank_idx_t bank;
        dram_cmd_t exp;
        if (pending.size() == 0) begin
            $display("A command was issued at %0t with no request waiting", $time);
            err_count++;
            return;
        end
        head = pending[0];
        bank = {head.addr.f.bg, head.addr.f.bank};
        exp  = expected_cmd(model_open[bank], model_row[bank], head);
        check_field("cmd_code", 32'(cmd_code), 32'(exp));
        check_field("cmd_bank", 32'(cmd_bank), 32'(bank));
        if (exp == CMD_ACTIVATE) begin
            check_field("cmd_row", 32'(cmd_row), 32'(head.addr.f.row));
        end
        if (exp == CMD_READ || exp == CMD_WRITE) begin
            check_field("cmd_col", 32'(cmd_col), 32'(head.addr.f.col));
        end
        check_field("cmd_data", cmd_data, (exp == CMD_WRITE) ? head.data : '0);
        if (last_code == CMD_PRECHARGE && cycle - last_cycle < `DRAM_PRE_LATENCY) begin
            $display("Command at %0t came too soon after a precharge", $time);
            err_count++;
        end
        if (last_code == CMD_ACTIVATE && cycle - last_cycle < `DRAM_ACT_LATENCY) begin
            $display("Command at %0t came too soon after an activate", $time);
            err_count++;
        end
        if (exp == CMD_READ && cycle - last_read < `DRAM_READ_GAP) begin
            $display("Read at %0t came too soon after the previous read", $time);
            err_count++;
        end
        case (exp)
            CMD_ACTIVATE: begin
                model_open[bank] = 1'b1;
                model_row[bank]  = head.addr.f.row;
            end
            CMD_PRECHARGE: model_open[bank] = 1'b0;
            default: begin
                void'(pending.pop_front());    // request retires with its access
                done_count++;
            end
        endcase
        if (exp == CMD_READ) begin
            last_read = cycle;
        end
        last_code  = exp;
        last_cycle = cycle;
    endtask

    always @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            pending.delete();
            for (int b = 0; b < `DRAM_NUM_BANKS; b++) begin
                model_open[b] = 1'b0;
            end
            cycle      = 0;
            last_cycle = -100;
            last_read  = -100;
            last_code  = CMD_READ;
            done_count = 0;
            err_count  = 0;
        end else begin
            cycle++;
            if (cmd_valid && cmd_ready) begin
                compare_command();
            end
            if (req_valid && req_ready) begin
                pending.push_back('{addr: req_addr, write: req_write, data: req_data});
            end
        end
    end

endmodule

// File: testbench/scheduler_sva.sv
`timescale 1ns/1ns
`include "dram_defines.svh"

module scheduler_sva import dram_geom_pkg::*, dram_cmd_pkg::*; (
    input logic clk_in,
    input logic rst_in,
    input logic req_valid,
    input logic req_ready,
    input logic cmd_ready,
    input logic cmd_valid,
    input dram_cmd_t cmd_code,
    input bank_idx_t cmd_bank,
    input row_t cmd_row,
    input col_t cmd_col,
    input logic [`DRAM_DATA_BITS-1:0] cmd_data,
    input logic [$clog2(`DRAM_QUEUE_DEPTH)-1:0] queue_wr_ptr
);
    int fail_count = 0;    // read by the testbench

    // a stalled command keeps every field
    cmd_hold: assert property (@(posedge clk_in) disable iff (rst_in)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_code) && $stable(cmd_bank)
            && $stable(cmd_row) && $stable(cmd_col) && $stable(cmd_data))
        else begin
            $error("command changed while stalled");
            fail_count++;
        end

    // first cycle out of reset has no command and an empty queue
    idle_after_reset: assert property (@(posedge clk_in)
        $fell(rst_in) |-> !cmd_valid && req_ready)
        else begin
            $error("cmd_valid high or req_ready low right after reset");
            fail_count++;
        end

    // write pointer only moves on an accepted request
    no_push_when_full: assert property (@(posedge clk_in) disable iff (rst_in)
        req_valid && !req_ready |=> $stable(queue_wr_ptr))
        else begin
            $error("request taken while req_ready low");
            fail_count++;
        end

endmodule

bind dram_scheduler_top scheduler_sva u_scheduler_sva (
    .*,
    .queue_wr_ptr(u_request_queue.wr_ptr)
);

// File: testbench/tb_dram_scheduler.sv
`timescale 1ns/1ns
`include "dram_defines.svh"

module tb_dram_scheduler import dram_geom_pkg::*, dram_cmd_pkg::*; ();
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RANDOM_REQS = 40;
    localparam int DEPTH = `DRAM_QUEUE_DEPTH;

    logic clk_in = 1'b0;
    logic rst_in;
    logic req_valid;
    dram_addr_t req_addr;
    logic req_write;
    logic [`DRAM_DATA_BITS-1:0] req_data;
    logic req_ready;
    logic cmd_ready;
    logic cmd_valid;
    dram_cmd_t cmd_code;
    bank_idx_t cmd_bank;
    row_t cmd_row;
    col_t cmd_col;
    logic [`DRAM_DATA_BITS-1:0] cmd_data;
    int done_count;
    int err_count;

    integer seed = 39589;
    logic [31:0] ready_rnd;
    logic random_ready_on = 1'b0;
    logic ready_level = 1'b1;
    int tb_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int errors_before = 0;
    dram_addr_t rand_addr [RANDOM_REQS];
    logic rand_write [RANDOM_REQS];
    logic [`DRAM_DATA_BITS-1:0] rand_data [RANDOM_REQS];

    always #50 clk_in = ~clk_in;

    dram_scheduler_top u_dram_scheduler_top (.*);
    scheduler_checker u_scheduler_checker (.*);

    // controller ready with random back-pressure only while enabled
    always @(negedge clk_in) begin
        if (random_ready_on) begin
            ready_rnd = $random(seed);
            cmd_ready = ready_rnd[0];
        end else begin
            cmd_ready = ready_level;
        end
    end

    function automatic dram_addr_t make_addr(bank_idx_t bank, row_t row, col_t col);
        dram_addr_t a;
        {a.f.bg, a.f.bank} = bank;
        a.f.row = row;
        a.f.col = col;
        return a;
    endfunction

    function automatic int error_total();
        return err_count + tb_errors + u_dram_scheduler_top.u_scheduler_sva.fail_count;
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("Timed out at %0t waiting for %s", $time, what);
        $display("Test FAILED");
        $finish;
    endtask

    // called and returns at a falling edge
    task automatic send_request(input dram_addr_t addr, input logic is_write,
                                input logic [`DRAM_DATA_BITS-1:0] data);
        int waited;
        waited    = 0;
        req_valid = 1'b1;
        req_addr  = addr;
        req_write = is_write;
        req_data  = data;
        while (!req_ready && waited < TIMEOUT_CYCLES) begin
            @(negedge clk_in);
            waited++;
        end
        if (!req_ready) begin
            stop_on_timeout("req_ready");
        end else begin
            @(negedge clk_in);    // taken on the rising edge in between
            req_valid = 1'b0;
        end
    endtask

    task automatic wait_done(input int target);
        int waited;
        waited = 0;
        while (done_count < target && waited < TIMEOUT_CYCLES) begin
            @(negedge clk_in);
            waited++;
        end
        if (done_count < target) begin
            stop_on_timeout("requests to complete");
        end
    endtask

    // mode changes on a rising edge so the ready driver never races them
    task automatic set_ready(input logic random_on, input logic level);
        @(posedge clk_in);
        random_ready_on = random_on;
        ready_level     = level;
        @(negedge clk_in);
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = error_total() - errors_before;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("%-16s %s (%0d errors)", name, (errs == 0) ? "passed" : "failed", errs);
        errors_before = error_total();
    endtask

    initial begin
        rst_in    = 1'b1;
        req_valid = 1'b0;
        req_addr  = '0;
        req_write = 1'b0;
        req_data  = '0;
        cmd_ready = 1'b1;
        repeat (16) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        send_request(make_addr(3'd2, 8'h11, 4'h3), 1'b0, '0);    // activate then read
        wait_done(1);
        finish_test("closed_bank");

        send_request(make_addr(3'd2, 8'h11, 4'h5), 1'b1, 32'hcafe_0001);
        wait_done(2);
        finish_test("row_hit");

        send_request(make_addr(3'd2, 8'h22, 4'h1), 1'b0, '0);    // row 0x11 still open
        wait_done(3);
        finish_test("row_conflict");

        for (int i = 0; i < 4; i++) begin
            send_request(make_addr(3'd5, 8'h40, col_t'(i)), 1'b0, '0);
        end
        wait_done(7);
        finish_test("read_gap");

        // few rows per bank so hits and conflicts both show up
        for (int i = 0; i < RANDOM_REQS; i++) begin
            rand_addr[i]  = make_addr(bank_idx_t'($random(seed)), row_t'($random(seed) & 3),
                                      col_t'($random(seed)));
            rand_write[i] = $random(seed) & 1;
            rand_data[i]  = $random(seed);
        end
        set_ready(1'b1, 1'b1);
        for (int i = 0; i < RANDOM_REQS; i++) begin
            send_request(rand_addr[i], rand_write[i], rand_data[i]);
        end
        wait_done(7 + RANDOM_REQS);
        set_ready(1'b0, 1'b1);
        finish_test("random_traffic");

        set_ready(1'b0, 1'b0);    // stall the controller so nothing drains
        for (int i = 0; i < DEPTH; i++) begin
            send_request(make_addr(bank_idx_t'(i), 8'h07, col_t'(i)), i[0], 32'h1000_0000 + i);
        end
        if (req_ready) begin
            $display("req_ready still high with %0d requests queued", DEPTH);
            tb_errors++;
        end
        set_ready(1'b0, 1'b1);
        wait_done(7 + RANDOM_REQS + DEPTH);
        finish_test("full_queue");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_total());
        if (error_total() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/bank_state_table.sv
`timescale 1ns/1ns
`include "dram_defines.svh"

module bank_state_table import dram_geom_pkg::*; (
    input  logic clk_in,
    input  logic rst_in,
    input  bank_idx_t head_bank,   // bank the head request targets
    input  logic act_fire,
    input  logic pre_fire,
    input  bank_idx_t fire_bank,
    input  row_t fire_row,
    output logic bank_open,
    output row_t open_row
);
    localparam int NUM_BANKS = `DRAM_NUM_BANKS;

    logic [NUM_BANKS-1:0] open_flag;
    row_t row_reg [NUM_BANKS];

    // open flags, all banks start precharged
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            open_flag <= '0;
        end else if (act_fire) begin
            open_flag[fire_bank] <= 1'b1;
        end else if (pre_fire) begin
            open_flag[fire_bank] <= 1'b0;
        end
    end

    // row register only matters while the flag is set
    always_ff @(posedge clk_in) begin
        if (act_fire) begin
            row_reg[fire_bank] <= fire_row;
        end
    end

    assign bank_open = open_flag[head_bank];
    assign open_row  = row_reg[head_bank];

endmodule

// File: verilog/cmd_sequencer.sv
`timescale 1ns/1ns
`include "dram_defines.svh"

module cmd_sequencer import dram_geom_pkg::*, dram_cmd_pkg::*; (
    input  logic clk_in,
    input  logic rst_in,
    input  logic head_valid,
    input  sched_req_t head_req,
    output logic head_pop,
    input  logic bank_open,
    input  row_t open_row,
    input  logic timer_busy,
    input  logic read_gap_busy,
    output logic act_fire,
    output logic pre_fire,
    output bank_idx_t fire_bank,
    output row_t fire_row,
    output logic start_pre,
    output logic start_act,
    output logic start_read,
    input  logic cmd_ready,
    output logic cmd_valid,
    output dram_cmd_t cmd_code,
    output bank_idx_t cmd_bank,
    output row_t cmd_row,
    output col_t cmd_col,
    output logic [`DRAM_DATA_BITS-1:0] cmd_data
);
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_DECIDE = 2'd1;
    localparam logic [1:0] ST_ISSUE  = 2'd2;
    localparam logic [1:0] ST_WAIT   = 2'd3;   // precharge or activate latency

    logic [1:0] state;
    dram_cmd_t next_code;
    logic row_hit;
    logic can_issue;
    logic xfer;
    logic rw_cmd;

    assign row_hit = bank_open && (open_row == head_req.addr.f.row);

    // command the head request needs next
    always_comb begin
        if (bank_open && !row_hit) begin
            next_code = CMD_PRECHARGE;   // another row is open
        end else if (!bank_open) begin
            next_code = CMD_ACTIVATE;
        end else if (head_req.write) begin
            next_code = CMD_WRITE;
        end else begin
            next_code = CMD_READ;
        end
    end

    assign can_issue = head_valid && !timer_busy &&
                       !((next_code == CMD_READ) && read_gap_busy);

    assign xfer   = cmd_valid && cmd_ready;
    assign rw_cmd = (cmd_code == CMD_READ) || (cmd_code == CMD_WRITE);

    assign head_pop   = xfer && rw_cmd;     // request done once its access goes out
    assign act_fire   = xfer && (cmd_code == CMD_ACTIVATE);
    assign pre_fire   = xfer && (cmd_code == CMD_PRECHARGE);
    assign fire_bank  = cmd_bank;
    assign fire_row   = cmd_row;
    assign start_pre  = pre_fire;
    assign start_act  = act_fire;
    assign start_read = xfer && (cmd_code == CMD_READ);

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state     <= ST_IDLE;
            cmd_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (head_valid) begin
                        state <= ST_DECIDE;
                    end
                end
                ST_DECIDE: begin
                    if (can_issue) begin
                        cmd_valid <= 1'b1;
                        state     <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (cmd_ready) begin   // hold everything until accepted
                        cmd_valid <= 1'b0;
                        state     <= rw_cmd ? ST_IDLE : ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (!timer_busy) begin
                        state <= ST_DECIDE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // command fields, loaded only when a command is chosen
    always_ff @(posedge clk_in) begin
        if ((state == ST_DECIDE) && can_issue) begin
            cmd_code <= next_code;
            cmd_bank <= bank_of(head_req.addr);
            cmd_row  <= head_req.addr.f.row;
            cmd_col  <= head_req.addr.f.col;
            cmd_data <= (next_code == CMD_WRITE) ? head_req.data : '0;
        end
    end

endmodule

// File: verilog/dram_cmd_pkg.sv
`include "dram_defines.svh"

package dram_cmd_pkg;

    import dram_geom_pkg::*;

    // command codes toward the controller
    typedef enum logic [1:0] {
        CMD_READ      = 2'd0,
        CMD_WRITE     = 2'd1,
        CMD_ACTIVATE  = 2'd2,
        CMD_PRECHARGE = 2'd3
    } dram_cmd_t;

    // one queued request
    typedef struct packed {
        dram_addr_t addr;
        logic write;                           // 1 for write, 0 for read
        logic [`DRAM_DATA_BITS-1:0] data;      // only used by writes
    } sched_req_t;

endpackage

// File: verilog/dram_geom_pkg.sv
`include "dram_defines.svh"

package dram_geom_pkg;

    typedef logic [`DRAM_BG_BITS+`DRAM_BANK_BITS-1:0] bank_idx_t;    // {bank group, bank}
    typedef logic [`DRAM_ROW_BITS-1:0] row_t;
    typedef logic [`DRAM_COL_BITS-1:0] col_t;

    // the request address, seen as one word or split into its fields
    typedef union packed {
        logic [`DRAM_BG_BITS+`DRAM_BANK_BITS+`DRAM_ROW_BITS+`DRAM_COL_BITS-1:0] flat;
        struct packed {
            logic [`DRAM_BG_BITS-1:0] bg;      // top bits
            logic [`DRAM_BANK_BITS-1:0] bank;
            row_t row;
            col_t col;                         // bottom bits
        } f;
    } dram_addr_t;

    // flat bank number of an address
    function automatic bank_idx_t bank_of(dram_addr_t addr);
        return {addr.f.bg, addr.f.bank};
    endfunction

endpackage

// File: verilog/dram_scheduler_top.sv
`timescale 1ns/1ns
`include "dram_defines.svh"

module dram_scheduler_top import dram_geom_pkg::*, dram_cmd_pkg::*; (
    input  logic clk_in,
    input  logic rst_in,
    // request side
    input  logic req_valid,
    input  dram_addr_t req_addr,
    input  logic req_write,
    input  logic [`DRAM_DATA_BITS-1:0] req_data,
    output logic req_ready,
    // command side
    input  logic cmd_ready,
    output logic cmd_valid,
    output dram_cmd_t cmd_code,
    output bank_idx_t cmd_bank,
    output row_t cmd_row,
    output col_t cmd_col,
    output logic [`DRAM_DATA_BITS-1:0] cmd_data
);
    logic head_valid;
    sched_req_t head_req;
    logic head_pop;
    bank_idx_t head_bank;
    logic bank_open;
    row_t open_row;
    logic act_fire;
    logic pre_fire;
    bank_idx_t fire_bank;
    row_t fire_row;
    logic start_pre;
    logic start_act;
    logic start_read;
    logic timer_busy;
    logic read_gap_busy;

    assign head_bank = bank_of(head_req.addr);

    request_queue u_request_queue (
        .clk_in, .rst_in,
        .req_valid, .req_addr, .req_write, .req_data, .req_ready,
        .head_valid, .head_req, .head_pop
    );

    bank_state_table u_bank_state_table (
        .clk_in, .rst_in,
        .head_bank, .act_fire, .pre_fire, .fire_bank, .fire_row,
        .bank_open, .open_row
    );

    timing_counter u_timing_counter (
        .clk_in, .rst_in,
        .start_pre, .start_act, .start_read,
        .timer_busy, .read_gap_busy
    );

    cmd_sequencer u_cmd_sequencer (
        .clk_in, .rst_in,
        .head_valid, .head_req, .head_pop,
        .bank_open, .open_row, .timer_busy, .read_gap_busy,
        .act_fire, .pre_fire, .fire_bank, .fire_row,
        .start_pre, .start_act, .start_read,
        .cmd_ready, .cmd_valid, .cmd_code, .cmd_bank, .cmd_row, .cmd_col, .cmd_data
    );

endmodule

// File: verilog/request_queue.sv
`timescale 1ns/1ns
`include "dram_defines.svh"

module request_queue import dram_geom_pkg::*, dram_cmd_pkg::*; (
    input  logic clk_in,
    input  logic rst_in,
    input  logic req_valid,
    input  dram_addr_t req_addr,
    input  logic req_write,
    input  logic [`DRAM_DATA_BITS-1:0] req_data,
    output logic req_ready,
    output logic head_valid,
    output sched_req_t head_req,
    input  logic head_pop
);
    localparam int DEPTH = `DRAM_QUEUE_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);

    sched_req_t mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0] count;      // one extra bit so full fits
    logic push;
    logic pop;

    assign req_ready  = (count != (PTR_BITS+1)'(DEPTH));
    assign head_valid = (count != '0);
    assign head_req   = mem[rd_ptr];

    assign push = req_valid && req_ready;
    assign pop  = head_pop && head_valid;

    always_ff @(posedge clk_in) begin
        if (push) begin
            mem[wr_ptr] <= '{addr: req_addr, write: req_write, data: req_data};
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: verilog/timing_counter.sv
`timescale 1ns/1ns
`include "dram_defines.svh"

module timing_counter (
    input  logic clk_in,
    input  logic rst_in,
    input  logic start_pre,
    input  logic start_act,
    input  logic start_read,
    output logic timer_busy,
    output logic read_gap_busy
);
    localparam int LAT_MAX = (`DRAM_ACT_LATENCY > `DRAM_PRE_LATENCY) ?
                             `DRAM_ACT_LATENCY : `DRAM_PRE_LATENCY;
    localparam int LAT_BITS = $clog2(LAT_MAX + 1);
    localparam int GAP_BITS = $clog2(`DRAM_READ_GAP + 1);

    logic [LAT_BITS-1:0] lat_cnt;  // precharge / activate wait
    logic [GAP_BITS-1:0] gap_cnt;  // read to read spacing

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            lat_cnt <= '0;
            gap_cnt <= '0;
        end else begin
            if (start_act) begin
                lat_cnt <= LAT_BITS'(`DRAM_ACT_LATENCY);
            end else if (start_pre) begin
                lat_cnt <= LAT_BITS'(`DRAM_PRE_LATENCY);
            end else if (lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1;
            end

            if (start_read) begin
                gap_cnt <= GAP_BITS'(`DRAM_READ_GAP);
            end else if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - 1'b1;
            end
        end
    end

    assign timer_busy    = (lat_cnt != '0);
    assign read_gap_busy = (gap_cnt != '0);

endmodule
